/* hdl/mips_alu.sv */
`timescale 1ns/10ps

module mips_alu import mips_pkg::*; (
    input  alu_op_t           alu_op,
    input  logic [word_w-1:0] a,
    input  logic [word_w-1:0] b,
    input  logic [4:0]        shamt,
    output logic [word_w-1:0] alu_result,
    output logic              branch_equal
);

    logic              less_signed;
    logic              less_unsigned;
    logic [word_w-1:0] sum;
    logic [word_w-1:0] diff;
    logic [word_w-1:0] shift_arith;

    assign sum = a + b;
    assign diff = a - b;

    assign less_signed = $signed(a) < $signed(b);
    assign less_unsigned = a < b;

    // Shifts always act on the rt operand
    assign shift_arith = $signed(b) >>> shamt;

    always_comb begin
        case (alu_op)
            alu_add:
                alu_result = sum;
            alu_sub:
                alu_result = diff;
            alu_and:
                alu_result = a & b;
            alu_or:
                alu_result = a | b;
            alu_xor:
                alu_result = a ^ b;
            alu_slt:
                alu_result = {{(word_w-1){1'b0}}, less_signed};
            alu_sltu:
                alu_result = {{(word_w-1){1'b0}}, less_unsigned};
            alu_sll:
                alu_result = b << shamt;
            alu_srl:
                alu_result = b >> shamt;
            alu_sra:
                alu_result = shift_arith;
            alu_lui:
                alu_result = {b[15:0], 16'h0000};
            default:
                alu_result = '0;
        endcase
    end

    // Control picks BEQ or BNE from this
    assign branch_equal = a == b;

endmodule

/* hdl/mips_control.sv */
`timescale 1ns/10ps

module mips_control import mips_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    output logic                  active,
    output logic [word_w-1:0]     address,
    output logic                  read,
    output logic                  write,
    output logic [word_w-1:0]     writedata,
    output logic [3:0]            byteenable,
    input  logic                  waitrequest,
    input  logic [word_w-1:0]     readdata,
    output instr_t                instr,
    output logic [reg_addr_w-1:0] rs_addr,
    output logic [reg_addr_w-1:0] rt_addr,
    input  logic [word_w-1:0]     rs_data,
    input  logic [word_w-1:0]     rt_data,
    output alu_op_t               alu_op,
    output logic [word_w-1:0]     alu_b,
    input  logic [word_w-1:0]     alu_result,
    input  logic                  branch_equal,
    output logic                  wr_en,
    output logic [reg_addr_w-1:0] wr_addr,
    output logic [word_w-1:0]     wr_data
);

    cpu_state_t        state;
    instr_t            ir;
    logic [word_w-1:0] pc;
    logic [word_w-1:0] jump_target;
    logic              delay_slot;

    logic [word_w-1:0] pc_plus4;
    logic [word_w-1:0] imm_sext;
    logic [word_w-1:0] imm_zext;
    logic [word_w-1:0] next_target;
    logic              is_j;
    logic              is_jr;
    logic              is_beq;
    logic              is_bne;
    logic              is_load;
    logic              is_store;
    logic              is_flow;
    logic              take_flow;
    logic              use_imm;
    logic              zero_ext;
    logic              reg_write;
    logic              dest_rd;
    logic              fetch_req;
    logic              aligned;

    assign pc_plus4 = pc + 32'd4;
    assign imm_sext = {{16{ir.i_fmt.imm[15]}}, ir.i_fmt.imm};
    assign imm_zext = {16'h0000, ir.i_fmt.imm};

    assign is_j = ir.j_fmt.opcode == op_j;
    assign is_jr = ir.r_fmt.opcode == op_r && ir.r_fmt.funct == fn_jr;
    assign is_beq = ir.i_fmt.opcode == op_beq;
    assign is_bne = ir.i_fmt.opcode == op_bne;
    assign is_load = ir.i_fmt.opcode == op_lw;
    assign is_store = ir.i_fmt.opcode == op_sw;
    assign is_flow = is_j || is_jr || is_beq || is_bne;
    assign take_flow = is_j || is_jr || (is_beq && branch_equal) || (is_bne && !branch_equal);

    // Branches are relative to the delay slot address
    always_comb begin
        if (is_j)
            next_target = {pc_plus4[31:28], ir.j_fmt.index, 2'b00};
        else if (is_jr)
            next_target = rs_data;
        else
            next_target = pc_plus4 + {imm_sext[29:0], 2'b00};
    end

    always_comb begin
        alu_op = alu_add;
        use_imm = 1'b1;
        zero_ext = 1'b0;
        reg_write = 1'b1;
        dest_rd = 1'b0;
        case (ir.r_fmt.opcode)
            op_r: begin
                use_imm = 1'b0;
                dest_rd = 1'b1;
                case (ir.r_fmt.funct)
                    fn_sll:  alu_op = alu_sll;
                    fn_srl:  alu_op = alu_srl;
                    fn_sra:  alu_op = alu_sra;
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sltu: alu_op = alu_sltu;
                    default: reg_write = 1'b0;
                endcase
            end
            op_addiu: alu_op = alu_add;
            op_slti:  alu_op = alu_slt;
            op_sltiu: alu_op = alu_sltu;
            op_andi: begin
                alu_op = alu_and;
                zero_ext = 1'b1;
            end
            op_ori: begin
                alu_op = alu_or;
                zero_ext = 1'b1;
            end
            op_xori: begin
                alu_op = alu_xor;
                zero_ext = 1'b1;
            end
            op_lui: begin
                alu_op = alu_lui;
                zero_ext = 1'b1;
            end
            op_beq, op_bne: begin
                alu_op = alu_sub;
                use_imm = 1'b0;
                reg_write = 1'b0;
            end
            // J, loads and stores; the adder gives the effective address
            default: reg_write = 1'b0;
        endcase
    end

    assign instr = ir;
    assign rs_addr = ir.r_fmt.rs;
    assign rt_addr = ir.r_fmt.rt;
    assign alu_b = !use_imm ? rt_data : (zero_ext ? imm_zext : imm_sext);

    // Bus side, quiet while reset is held
    assign aligned = alu_result[1:0] == 2'b00;
    assign fetch_req = !reset && state == st_fetch && pc != halt_address;
    assign read = fetch_req || (!reset && state == st_mem && is_load && aligned);
    assign write = !reset && state == st_mem && is_store && aligned;
    assign address = (state == st_mem) ? alu_result : pc;
    assign writedata = rt_data;
    assign byteenable = (read || write) ? 4'b1111 : 4'b0000;

    // Register write port
    assign wr_en = (state == st_exec && reg_write)
                || (state == st_mem && is_load && aligned && !waitrequest);
    assign wr_addr = (state == st_exec && dest_rd) ? ir.r_fmt.rd : ir.i_fmt.rt;
    assign wr_data = (state == st_mem) ? readdata : alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_fetch;
            pc <= reset_vector;
            active <= 1'b1;
            delay_slot <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    if (pc == halt_address) begin
                        state <= st_halted;
                        active <= 1'b0;
                    end else if (!waitrequest) begin
                        state <= st_exec;
                    end
                end
                st_exec: begin
                    pc <= delay_slot ? jump_target : pc_plus4;
                    delay_slot <= take_flow;
                    state <= (is_load || is_store) ? st_mem : st_fetch;
                end
                st_mem: begin
                    // Misaligned access gives up after one idle cycle
                    if (!aligned || !waitrequest)
                        state <= st_fetch;
                end
                st_halted: state <= st_halted;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_req && !waitrequest)
            ir <= readdata;
        if (state == st_exec && take_flow)
            jump_target <= next_target;
    end

    a_bus_aligned: assert property (@(posedge clk) disable iff (reset)
        (read || write) |-> address[1:0] == 2'b00);

    a_no_flow_in_slot: assert property (@(posedge clk) disable iff (reset)
        (state == st_exec && delay_slot) |-> !is_flow);

endmodule

/* hdl/mips_cpu_bus.sv */
`timescale 1ns/10ps

module mips_cpu_bus import mips_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    output logic              active,
    output logic [word_w-1:0] register_v0,
    output logic [word_w-1:0] address,
    output logic              read,
    output logic              write,
    output logic [word_w-1:0] writedata,
    output logic [3:0]        byteenable,
    input  logic              waitrequest,
    input  logic [word_w-1:0] readdata
);

    instr_t                instr;
    logic [reg_addr_w-1:0] rs_addr;
    logic [reg_addr_w-1:0] rt_addr;
    logic [word_w-1:0]     rs_data;
    logic [word_w-1:0]     rt_data;
    alu_op_t               alu_op;
    logic [word_w-1:0]     alu_b;
    logic [word_w-1:0]     alu_result;
    logic                  branch_equal;
    logic                  wr_en;
    logic [reg_addr_w-1:0] wr_addr;
    logic [word_w-1:0]     wr_data;

    mips_control mips_control_i (
        .clk, .reset, .active,
        .address, .read, .write, .writedata, .byteenable, .waitrequest, .readdata,
        .instr, .rs_addr, .rt_addr, .rs_data, .rt_data,
        .alu_op, .alu_b, .alu_result, .branch_equal,
        .wr_en, .wr_addr, .wr_data
    );

    mips_reg_file mips_reg_file_i (
        .clk, .reset,
        .rs_addr, .rt_addr, .rs_data, .rt_data,
        .wr_en, .wr_addr, .wr_data,
        .register_v0
    );

    // Operand a is always rs, shift amount straight from the instruction
    mips_alu mips_alu_i (
        .alu_op,
        .a            (rs_data),
        .b            (alu_b),
        .shamt        (instr.r_fmt.shamt),
        .alu_result,
        .branch_equal
    );

endmodule

/* hdl/mips_pkg.sv */
package mips_pkg;

    localparam int word_w = 32;
    localparam int reg_addr_w = 5;

    localparam logic [word_w-1:0] reset_vector = 32'hbfc0_0000;
    localparam logic [word_w-1:0] halt_address = 32'h0000_0000;

    localparam logic [reg_addr_w-1:0] reg_zero = 5'd0;
    localparam logic [reg_addr_w-1:0] reg_v0 = 5'd2;

    typedef enum logic [5:0] {
        op_r     = 6'h00,
        op_j     = 6'h02,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addiu = 6'h09,
        op_slti  = 6'h0a,
        op_sltiu = 6'h0b,
        op_andi  = 6'h0c,
        op_ori   = 6'h0d,
        op_xori  = 6'h0e,
        op_lui   = 6'h0f,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_jr   = 6'h08,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt,
        alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_t;

    typedef enum logic [1:0] {
        st_fetch, st_exec, st_mem, st_halted
    } cpu_state_t;

    // Instruction word seen as R, I or J format
    typedef union packed {
        struct packed {
            opcode_t               opcode;
            logic [reg_addr_w-1:0] rs;
            logic [reg_addr_w-1:0] rt;
            logic [reg_addr_w-1:0] rd;
            logic [4:0]            shamt;
            funct_t                funct;
        } r_fmt;
        struct packed {
            opcode_t               opcode;
            logic [reg_addr_w-1:0] rs;
            logic [reg_addr_w-1:0] rt;
            logic [15:0]           imm;
        } i_fmt;
        struct packed {
            opcode_t     opcode;
            logic [25:0] index;
        } j_fmt;
    } instr_t;

endpackage

/* hdl/mips_reg_file.sv */
`timescale 1ns/10ps

module mips_reg_file import mips_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [reg_addr_w-1:0] rs_addr,
    input  logic [reg_addr_w-1:0] rt_addr,
    output logic [word_w-1:0]     rs_data,
    output logic [word_w-1:0]     rt_data,
    input  logic                  wr_en,
    input  logic [reg_addr_w-1:0] wr_addr,
    input  logic [word_w-1:0]     wr_data,
    output logic [word_w-1:0]     register_v0
);

    logic [word_w-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**reg_addr_w; i++)
                regs[i] <= '0;
        end else if (wr_en && wr_addr != reg_zero) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Both read ports are combinational
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    assign register_v0 = regs[reg_v0];

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module mips_tb \
    -Mdir obj_dir -o mips_tb_sim -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mips_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
    echo "No pass message found in $LOG"
    exit 1
fi
exit 0

/* sim/avalon_mem_model.sv */
`timescale 1ns/10ps

module avalon_mem_model import mips_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [word_w-1:0] address,
    input  logic              read,
    input  logic              write,
    input  logic [word_w-1:0] writedata,
    input  logic [3:0]        byteenable,
    output logic              waitrequest,
    output logic [word_w-1:0] readdata
);

    logic [word_w-1:0] mem [logic [word_w-1:0]];
    logic [31:0]       lcg_state;
    logic              busy;
    int                stall_left;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Unwritten words return a pattern built from their own address
    function automatic logic [word_w-1:0] fetch_word(input logic [word_w-1:0] addr);
        logic [word_w-1:0] key;
        key = {addr[31:2], 2'b00};
        if (mem.exists(key))
            return mem[key];
        return key ^ 32'hc3a5_5a3c;
    endfunction

    task automatic store_word(input logic [word_w-1:0] addr, input logic [word_w-1:0] data);
        mem[{addr[31:2], 2'b00}] = data;
    endtask

    task automatic clear_all();
        mem.delete();
    endtask

    initial begin
        lcg_state = 32'd16;
        busy = 1'b0;
        stall_left = 0;
        waitrequest = 1'b1;
        readdata = '0;
    end

    always @(posedge clk) begin
        logic              was_reset;
        logic [word_w-1:0] word;
        was_reset = reset;
        if (!was_reset && (read || write) && !waitrequest) begin
            if (write) begin
                word = fetch_word(address);
                for (int i = 0; i < 4; i++)
                    if (byteenable[i])
                        word[8*i +: 8] = writedata[8*i +: 8];
                store_word(address, word);
            end
            busy = 1'b0;
        end
        #2;
        if (was_reset) begin
            busy = 1'b0;
            waitrequest = 1'b1;
        end else if (read || write) begin
            // New transfer picks 0 to 3 stall cycles
            if (!busy) begin
                busy = 1'b1;
                lcg_state = next_random(lcg_state);
                stall_left = int'(lcg_state[17:16]);
            end else if (stall_left > 0) begin
                stall_left--;
            end
            waitrequest = stall_left != 0;
        end else begin
            waitrequest = 1'b1;
        end
        readdata = fetch_word(address);
    end

endmodule

/* sim/mips_tb.sv */
`timescale 1ns/10ps

module mips_tb import mips_pkg::*; ();

    localparam int n_programs = 4;
    localparam int clk_period = 40;
    localparam int halt_limit = 180;

    localparam logic [4:0] reg_t0 = 5'd8;
    localparam logic [4:0] reg_t1 = 5'd9;
    localparam logic [4:0] reg_t2 = 5'd10;
    localparam logic [4:0] reg_t3 = 5'd11;

    localparam funct_t rr_functs [10] = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor,
                                          fn_slt, fn_sltu, fn_sll, fn_srl, fn_sra};
    localparam opcode_t imm_opcodes [7] = '{op_addiu, op_slti, op_sltiu, op_andi,
                                            op_ori, op_xori, op_lui};

    logic              clk;
    logic              reset;
    logic              active;
    logic [word_w-1:0] register_v0;
    logic [word_w-1:0] address;
    logic              read;
    logic              write;
    logic [word_w-1:0] writedata;
    logic [3:0]        byteenable;
    logic              waitrequest;
    logic [word_w-1:0] readdata;

    logic [31:0]       prog [$];
    logic [31:0]       lcg_state;
    logic [31:0]       expected_v0;
    logic [31:0]       exp_wr_addr [2];
    logic [31:0]       exp_wr_data [2];
    int                exp_wr_count;
    int                wr_count;
    int                value_errors;
    int                other_errors;
    logic              await_first;

    mips_cpu_bus mips_cpu_bus_i (
        .clk, .reset, .active, .register_v0,
        .address, .read, .write, .writedata, .byteenable, .waitrequest, .readdata
    );

    avalon_mem_model mem_i (
        .clk, .reset, .address, .read, .write, .writedata, .byteenable,
        .waitrequest, .readdata
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_operand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] rtype_word(input funct_t fn, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [4:0] rd,
                                               input logic [4:0] sh);
        return {op_r, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] itype_word(input opcode_t op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jtype_word(input opcode_t op, input logic [25:0] index);
        return {op, index};
    endfunction

    // Reference results following the MIPS32 definitions
    function automatic logic [31:0] rtype_result(input funct_t fn, input logic [31:0] a,
                                                 input logic [31:0] b, input logic [4:0] sh);
        case (fn)
            fn_addu: return a + b;
            fn_subu: return a - b;
            fn_and:  return a & b;
            fn_or:   return a | b;
            fn_xor:  return a ^ b;
            fn_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            fn_sltu: return (a < b) ? 32'd1 : 32'd0;
            fn_sll:  return b << sh;
            fn_srl:  return b >> sh;
            fn_sra:  return (b >> sh) | ({32{b[31]}} << (6'd32 - {1'b0, sh}));
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] itype_result(input opcode_t op, input logic [31:0] a,
                                                 input logic [15:0] imm);
        logic [31:0] se;
        logic [31:0] ze;
        se = {{16{imm[15]}}, imm};
        ze = {16'h0000, imm};
        case (op)
            op_addiu: return a + se;
            op_slti:  return ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
            op_sltiu: return (a < se) ? 32'd1 : 32'd0;
            op_andi:  return a & ze;
            op_ori:   return a | ze;
            op_xori:  return a ^ ze;
            op_lui:   return {imm, 16'h0000};
            default:  return 32'd0;
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic load_constant(input logic [4:0] rt, input logic [31:0] value);
        emit(itype_word(op_lui, reg_zero, rt, value[31:16]));
        emit(itype_word(op_ori, rt, rt, value[15:0]));
    endtask

    // JR to address zero plus a NOP in its delay slot
    task automatic emit_halt();
        emit(rtype_word(fn_jr, reg_zero, reg_zero, reg_zero, 5'd0));
        emit(32'h0000_0000);
    endtask

    task automatic start_program();
        prog.delete();
        expected_v0 = '0;
        exp_wr_count = 0;
    endtask

    task automatic build_rr_program();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [4:0]  sh;
        start_program();
        a = next_operand();
        b = next_operand();
        load_constant(reg_t0, a);
        load_constant(reg_t1, b);
        for (int k = 0; k < 10; k++) begin
            r = next_operand();
            sh = (k >= 7) ? r[4:0] : 5'd0;
            if (k >= 7)
                emit(rtype_word(rr_functs[k], reg_zero, reg_t1, reg_t2, sh));
            else
                emit(rtype_word(rr_functs[k], reg_t0, reg_t1, reg_t2, sh));
            emit(rtype_word(fn_addu, reg_v0, reg_t2, reg_v0, 5'd0));
            expected_v0 = expected_v0 + rtype_result(rr_functs[k], a, b, sh);
        end
        emit_halt();
    endtask

    task automatic build_imm_program();
        logic [31:0] a;
        logic [31:0] r;
        start_program();
        a = next_operand();
        load_constant(reg_t0, a);
        for (int k = 0; k < 7; k++) begin
            r = next_operand();
            emit(itype_word(imm_opcodes[k], reg_t0, reg_t2, r[15:0]));
            emit(rtype_word(fn_addu, reg_v0, reg_t2, reg_v0, 5'd0));
            expected_v0 = expected_v0 + itype_result(imm_opcodes[k], a, r[15:0]);
        end
        emit_halt();
    endtask

    // Two aligned stores, one misaligned store, then aligned and misaligned loads
    task automatic build_mem_program();
        logic [31:0] a;
        logic [31:0] b;
        start_program();
        a = next_operand();
        b = next_operand();
        load_constant(reg_t0, a);
        load_constant(reg_t1, b);
        emit(itype_word(op_ori, reg_zero, reg_t3, 16'h1000));
        emit(itype_word(op_sw, reg_t3, reg_t0, 16'd0));
        emit(itype_word(op_sw, reg_t3, reg_t1, 16'd4));
        emit(itype_word(op_sw, reg_t3, reg_t1, 16'd2));
        emit(itype_word(op_lw, reg_t3, reg_v0, 16'd0));
        emit(itype_word(op_lw, reg_t3, reg_v0, 16'd5));
        emit_halt();
        exp_wr_addr[0] = 32'h0000_1000;
        exp_wr_data[0] = a;
        exp_wr_addr[1] = 32'h0000_1004;
        exp_wr_data[1] = b;
        exp_wr_count = 2;
        expected_v0 = a;
    endtask

    task automatic build_branch_program();
        logic [31:0] r;
        logic [31:0] jump_addr;
        start_program();
        r = next_operand();
        jump_addr = reset_vector + 32'd44;
        emit(itype_word(op_addiu, reg_zero, reg_t0, r[15:0]));
        emit(itype_word(op_addiu, reg_zero, reg_t1, r[15:0]));
        emit(itype_word(op_beq, reg_t0, reg_t1, 16'd2));
        emit(itype_word(op_addiu, reg_v0, reg_v0, 16'd1));
        emit(itype_word(op_addiu, reg_v0, reg_v0, 16'd2));
        emit(itype_word(op_bne, reg_t0, reg_t1, 16'd5));
        emit(itype_word(op_addiu, reg_v0, reg_v0, 16'd4));
        emit(itype_word(op_addiu, reg_v0, reg_v0, 16'd8));
        emit(jtype_word(op_j, jump_addr[27:2]));
        emit(itype_word(op_addiu, reg_v0, reg_v0, 16'd16));
        emit(itype_word(op_addiu, reg_v0, reg_v0, 16'd32));
        emit_halt();
        expected_v0 = 32'd29;
    endtask

    task automatic run_program(input int id);
        int cycles;
        reset = 1'b1;
        mem_i.clear_all();
        foreach (prog[i])
            mem_i.store_word(reset_vector + 32'(4 * i), prog[i]);
        repeat (8) @(posedge clk);
        #2 reset = 1'b0;
        cycles = 0;
        while (active !== 1'b0 && cycles < halt_limit) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (active !== 1'b0) begin
            other_errors++;
            $display("Program %0d did not halt within %0d cycles", id, halt_limit);
        end
        repeat (4) @(posedge clk);
        #2;
        assert (wr_count == exp_wr_count) else begin
            value_errors++;
            $display("** Error: %0t write count = %0d, expected %0d",
                     $time, wr_count, exp_wr_count);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            wr_count <= 0;
            await_first <= 1'b1;
        end else begin
            if (write && !waitrequest)
                wr_count <= wr_count + 1;
            if (read || write)
                await_first <= 1'b0;
        end
    end

    a_first_address: assert property (@(posedge clk) disable iff (reset)
        (await_first && (read || write)) |-> address == reset_vector)
        else begin
            value_errors++;
            $display("** Error: %0t address = %h, expected %h",
                     $time, $sampled(address), reset_vector);
        end

    a_first_read: assert property (@(posedge clk) disable iff (reset)
        (await_first && (read || write)) |-> read && !write)
        else begin
            value_errors++;
            $display("** Error: %0t read = %b, expected 1", $time, $sampled(read));
        end

    a_first_byteenable: assert property (@(posedge clk) disable iff (reset)
        (await_first && (read || write)) |-> byteenable == 4'b1111)
        else begin
            value_errors++;
            $display("** Error: %0t byteenable = %b, expected 1111",
                     $time, $sampled(byteenable));
        end

    a_first_active: assert property (@(posedge clk) disable iff (reset)
        (await_first && (read || write)) |-> active)
        else begin
            value_errors++;
            $display("** Error: %0t active = %b, expected 1", $time, $sampled(active));
        end

    a_hold_on_wait: assert property (@(posedge clk) disable iff (reset)
        ((read || write) && waitrequest) |=> $stable(address) && $stable(read)
            && $stable(write) && $stable(writedata) && $stable(byteenable))
        else begin
            other_errors++;
            $display("Bus request changed while waitrequest was high at %0t", $time);
        end

    a_write_address: assert property (@(posedge clk) disable iff (reset)
        (write && !waitrequest) |-> address == exp_wr_addr[wr_count[0]])
        else begin
            value_errors++;
            $display("** Error: %0t address = %h, expected %h",
                     $time, $sampled(address), exp_wr_addr[$sampled(wr_count[0])]);
        end

    a_write_data: assert property (@(posedge clk) disable iff (reset)
        (write && !waitrequest) |-> writedata == exp_wr_data[wr_count[0]])
        else begin
            value_errors++;
            $display("** Error: %0t writedata = %h, expected %h",
                     $time, $sampled(writedata), exp_wr_data[$sampled(wr_count[0])]);
        end

    a_write_byteenable: assert property (@(posedge clk) disable iff (reset)
        (write && !waitrequest) |-> byteenable == 4'b1111)
        else begin
            value_errors++;
            $display("** Error: %0t byteenable = %b, expected 1111",
                     $time, $sampled(byteenable));
        end

    a_final_v0: assert property (@(posedge clk) disable iff (reset)
        $fell(active) |-> register_v0 == expected_v0)
        else begin
            value_errors++;
            $display("** Error: %0t register_v0 = %h, expected %h",
                     $time, $sampled(register_v0), expected_v0);
        end

    a_idle_after_halt: assert property (@(posedge clk) disable iff (reset)
        !active |-> !read && !write)
        else begin
            other_errors++;
            $display("Bus request made after the processor halted at %0t", $time);
        end

    initial begin
        repeat (n_programs * 200) @(posedge clk);
        $display("Watchdog expired before all programs finished");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        reset = 1'b1;
        lcg_state = 32'd16;
        expected_v0 = '0;
        exp_wr_count = 0;
        exp_wr_addr = '{default: '0};
        exp_wr_data = '{default: '0};
        value_errors = 0;
        other_errors = 0;
        @(posedge clk);
        #2;
        build_rr_program();
        run_program(1);
        build_imm_program();
        run_program(2);
        build_mem_program();
        run_program(3);
        build_branch_program();
        run_program(4);
        $display("Checks finished: %0d value errors, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* sources.f */
hdl/mips_pkg.sv
hdl/mips_alu.sv
hdl/mips_reg_file.sv
hdl/mips_control.sv
hdl/mips_cpu_bus.sv
sim/avalon_mem_model.sv
sim/mips_tb.sv
